//--- files.f
+incdir+common
+incdir+tb
common/npc_pkg.sv
src/sdp_bram.sv
src/sdp_lutram.sv
npc/npc_ras.sv
npc/core_npc.sv
src/npc_top.sv
tb/tb_npc.sv

//--- Makefile
# Verilator build and run for the next-PC stage testbench

VERILATOR ?= verilator
TOP       ?= tb_npc
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/npc_tests.svh
task automatic sequential_fetch_stall();
  logic [31:0] exp_pc;
  exp_pc = `NPC_RESET_PC;
  for (int i = 0; i < 6; i++) begin
    settle();
    check_value("seq pc0", fetch_pc[0], exp_pc);
    check_value("seq pc1", fetch_pc[1], exp_pc + 32'd4);
    check_value("seq valid", 32'(fetch_valid), 32'h3);
    tick();
    exp_pc = exp_pc + 32'd8;
  end
  stall = 1'b1;
  for (int i = 0; i < 3; i++) begin
    settle();
    check_value("stall pc0", fetch_pc[0], exp_pc);
    check_value("stall valid", 32'(fetch_valid), 32'h0);
    tick();
  end
  stall = 1'b0;
  settle();
  check_value("resume valid", 32'(fetch_valid), 32'h3);
  tick();
  settle();
  check_value("resume pc0", fetch_pc[0], exp_pc + 32'd8);
  tick();
  stall = 1'b1;
endtask

task automatic unaligned_redirect();
  logic [31:0] tgt;
  logic [31:0] base;
  tgt  = make_pc(6'd50, 1'b1);
  base = tgt & ~32'h4;
  redirect_to(tgt);
  settle();
  check_value("redir pc0", fetch_pc[0], base);
  check_value("redir pc1", fetch_pc[1], tgt);
  check_value("redir valid", 32'(fetch_valid), 32'h2);
  for (int i = 1; i <= 2; i++) begin
    tick();
    settle();
    check_value("after redir pc0", fetch_pc[0], base + 32'(8 * i));
    check_value("after redir valid", 32'(fetch_valid), 32'h3);
  end
  tick();
  stall = 1'b1;
endtask

task automatic jump_training();
  logic [31:0] pc_j;
  logic [31:0] tgt_j;
  logic [31:0] pc_s;
  logic [31:0] tgt_s;
  pc_j  = make_pc(6'd1, 1'b0);
  tgt_j = make_pc(6'd40, 1'b0);
  send_correction(pc_j, 1'b1, 1'b1, TGT_IMM, tgt_j, '0, '0, m_wr);
  // start one group early so fetch walks into the branch
  redirect_to(pc_j - 32'd8);
  wait_group(pc_j);
  check_value("jmp valid", 32'(fetch_valid), 32'h1);
  check_value("jmp taken", 32'(fetch_pred.taken), 32'h1);
  check_value("jmp target", fetch_pred.target, tgt_j);
  tick();
  stall = 1'b1;
  settle();
  check_value("jmp next pc0", fetch_pc[0], tgt_j);

  // branch in slot 1 keeps both slots
  pc_s  = make_pc(6'd3, 1'b1);
  tgt_s = make_pc(6'd41, 1'b0);
  send_correction(pc_s, 1'b1, 1'b1, TGT_IMM, tgt_s, '0, '0, m_wr);
  redirect_to(pc_s & ~32'h4);
  settle();
  check_value("slot1 valid", 32'(fetch_valid), 32'h3);
  check_value("slot1 taken", 32'(fetch_pred.taken), 32'h1);
  tick();
  stall = 1'b1;
  settle();
  check_value("slot1 next pc0", fetch_pc[0], tgt_s);
endtask

task automatic conditional_direction();
  logic [31:0] pc_c;
  logic [31:0] tgt_c;
  logic [31:0] rnd;
  logic        t;
  logic        exp_taken;
  logic [1:0]  lphr_in;
  logic [3:0]  new_hist;
  pc_c  = make_pc(6'd10, 1'b0);
  tgt_c = make_pc(6'd42, 1'b0);
  for (int i = 0; i < 12; i++) begin
    rnd = lfsr_bits(1);
    t   = rnd[0];
    if (i % 2 == 1) begin
      rnd     = lfsr_bits(2);
      lphr_in = rnd[1:0];
    end else begin
      lphr_in = m_lpht[m_hist];
    end
    send_correction(pc_c, t, 1'b0, TGT_IMM, tgt_c, m_hist, lphr_in, m_wr);
    new_hist         = {m_hist[2:0], t};
    m_lpht[new_hist] = counter_step(lphr_in, t);
    m_hist           = new_hist;
    exp_taken        = m_lpht[m_hist][1];
    redirect_to(pc_c);
    settle();
    check_value("cond history", 32'(fetch_pred.history), 32'(m_hist));
    check_value("cond lphr", 32'(fetch_pred.lphr), 32'(m_lpht[m_hist]));
    check_value("cond taken", 32'(fetch_pred.taken), 32'(exp_taken));
    check_value("cond valid", 32'(fetch_valid), exp_taken ? 32'h1 : 32'h3);
    tick();
    stall = 1'b1;
    settle();
    check_value("cond next pc0", fetch_pc[0], exp_taken ? tgt_c : pc_c + 32'd8);
  end
endtask

task automatic call_return_ras();
  logic [31:0] pc_call;
  logic [31:0] tgt_func;
  logic [31:0] pc_ret;
  logic [31:0] pc_x;
  logic [31:0] rnd;
  ras_ptr_t    p;
  pc_call  = make_pc(6'd20, 1'b0);
  tgt_func = make_pc(6'd44, 1'b0);
  pc_ret   = make_pc(6'd25, 1'b0);
  pc_x     = make_pc(6'd30, 1'b0);
  send_correction(pc_call, 1'b1, 1'b1, TGT_CALL, tgt_func, '0, '0, m_wr);
  send_correction(pc_ret, 1'b1, 1'b1, TGT_RETURN, make_pc(6'd45, 1'b0), '0, '0, m_wr);
  settle();
  check_value("trained ras ptr", 32'(fetch_pred.ras_ptr), 32'(m_wr));

  redirect_to(pc_call);
  settle();
  check_value("call target", fetch_pred.target, tgt_func);
  check_value("call valid", 32'(fetch_valid), 32'h1);
  tick();
  stall = 1'b1;
  push_ras_model(pc_call + 32'd4);
  settle();
  check_value("call next pc0", fetch_pc[0], tgt_func);
  check_value("push ras ptr", 32'(fetch_pred.ras_ptr), 32'(m_wr));

  redirect_to(pc_ret);
  settle();
  check_value("ret target", fetch_pred.target, pc_call + 32'd4);
  check_value("ret model top", fetch_pred.target, m_stack[m_rd]);
  tick();
  stall = 1'b1;
  pop_ras_model();
  settle();
  check_value("ret next pc1", fetch_pc[1], pc_call + 32'd4);
  check_value("pop ras ptr", 32'(fetch_pred.ras_ptr), 32'(m_wr));

  // repair from a corrected call at a chosen pointer
  rnd = lfsr_bits(3);
  p   = rnd[2:0];
  send_correction(pc_x, 1'b1, 1'b1, TGT_CALL, make_pc(6'd46, 1'b0), '0, '0, p);
  settle();
  check_value("repair ras ptr", 32'(fetch_pred.ras_ptr), 32'(m_wr));
  redirect_to(pc_ret);
  settle();
  check_value("repaired ret target", fetch_pred.target, pc_x + 32'd4);
  check_value("repaired ret ptr", 32'(fetch_pred.ras_ptr), 32'(m_wr));
  tick();
  stall = 1'b1;
  pop_ras_model();
  settle();
  check_value("repaired next pc1", fetch_pc[1], pc_x + 32'd4);
endtask

//--- tb/tb_npc.sv
`timescale 1ns/1ns
`include "npc_cfg.svh"

module tb_npc import npc_pkg::*; ();

  logic             clk = 1'b0;
  logic             rst_n;
  logic             redirect;
  logic [31:0]      redirect_target;
  logic             stall;
  logic [1:0][31:0] fetch_pc;
  logic [1:0]       fetch_valid;
  bpu_predict_t     fetch_pred;
  bpu_correct_t     correct;

  logic [31:0]      lfsr_state = 32'h2ee8;
  int               err_count = 0;
  int               check_count = 0;

  // reference model state
  logic [31:0]      m_stack [8];
  ras_ptr_t         m_wr;
  ras_ptr_t         m_rd;
  logic [3:0]       m_hist;
  logic [1:0]       m_lpht [16] = '{default: '0};

  always #4 clk = ~clk;

  npc_top dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .redirect_i        (redirect),
    .redirect_target_i (redirect_target),
    .stall_i           (stall),
    .pc_o              (fetch_pc),
    .valid_o           (fetch_valid),
    .predict_o         (fetch_pred),
    .correct_i         (correct)
  );

  // galois lfsr stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return val;
  endfunction

  // random upper bits around a chosen btb index and slot
  function automatic logic [31:0] make_pc(input logic [5:0] idx, input logic slot);
    logic [31:0] upper;
    upper = lfsr_bits(23);
    return {upper[22:0], idx, slot, 2'b00};
  endfunction

  function automatic logic [1:0] counter_step(input logic [1:0] cnt, input logic t);
    case (cnt)
      2'b00:   return {1'b0, t};
      2'b01:   return {t, 1'b0};
      2'b10:   return {t, 1'b1};
      default: return {1'b1, t};
    endcase
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic settle();
    #2;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic repair_ras_model(input ras_ptr_t p, input logic is_call,
                                  input logic [31:0] pc);
    if (is_call) begin
      m_stack[p] = pc + 32'd4;
      m_wr = p + 1'b1;
      m_rd = p;
    end else begin
      m_wr = p;
      m_rd = p - 1'b1;
    end
  endtask

  task automatic push_ras_model(input logic [31:0] addr);
    m_stack[m_wr] = addr;
    m_rd = m_wr;
    m_wr = m_wr + 1'b1;
  endtask

  task automatic pop_ras_model();
    m_wr = m_wr - 1'b1;
    m_rd = m_rd - 1'b1;
  endtask

  // one miss correction while fetch is stalled
  task automatic send_correction(input logic [31:0] pc, input logic taken,
                                 input logic uncond, input target_type_e ttype,
                                 input logic [31:0] target, input logic [3:0] hist,
                                 input logic [1:0] lphr, input ras_ptr_t ptr);
    tick();
    correct.miss             = 1'b1;
    correct.pc               = pc;
    correct.true_taken       = taken;
    correct.true_uncond      = uncond;
    correct.true_target_type = ttype;
    correct.true_target      = target;
    correct.history          = hist;
    correct.lphr             = lphr;
    correct.ras_ptr          = ptr;
    tick();
    correct.miss = 1'b0;
    repair_ras_model(ptr, ttype == TGT_CALL, pc);
  endtask

  task automatic redirect_to(input logic [31:0] addr);
    tick();
    stall           = 1'b0;
    redirect        = 1'b1;
    redirect_target = addr;
    tick();
    redirect = 1'b0;
  endtask

  task automatic wait_group(input logic [31:0] addr);
    int cycles;
    cycles = 0;
    settle();
    while (fetch_pc[0] !== addr && cycles < 16) begin
      tick();
      settle();
      cycles++;
    end
    if (fetch_pc[0] !== addr) begin
      err_count++;
      $display("timeout: fetch never reached the group at %h", addr);
    end
  endtask

  `include "npc_tests.svh"

  initial begin
    rst_n           = 1'b0;
    redirect        = 1'b0;
    redirect_target = '0;
    stall           = 1'b0;
    correct         = '0;
    m_wr            = '0;
    m_rd            = '0;
    m_hist          = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    sequential_fetch_stall();
    unaligned_redirect();
    jump_training();
    conditional_direction();
    call_return_ras();
    $display("checks %0d errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // guard against a hung run
  initial begin
    #50000;
    $display("timeout: simulation did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule

//--- src/npc_top.sv
`timescale 1ns/1ns

module npc_top import npc_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             redirect_i,
  input  logic [31:0]      redirect_target_i,
  input  logic             stall_i,
  output logic [1:0][31:0] pc_o,
  output logic [1:0]       valid_o,
  output bpu_predict_t     predict_o,
  input  bpu_correct_t     correct_i
);

  logic [1:0][31:0] fetch_pc;
  logic [1:0]       fetch_valid;
  bpu_predict_t     fetch_predict;

  // next-pc stage
  core_npc u_core_npc (
    .clk               (clk),
    .rst_n             (rst_n),
    .redirect_i        (redirect_i),
    .redirect_target_i (redirect_target_i),
    .stall_i           (stall_i),
    .pc_o              (fetch_pc),
    .valid_o           (fetch_valid),
    .predict_o         (fetch_predict),
    .correct_i         (correct_i)
  );

  assign pc_o      = fetch_pc;
  assign valid_o   = fetch_valid;
  assign predict_o = fetch_predict;

endmodule

//--- npc/core_npc.sv
`timescale 1ns/1ns
`include "npc_cfg.svh"

module core_npc import npc_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             redirect_i,
  input  logic [31:0]      redirect_target_i,
  input  logic             stall_i,
  output logic [1:0][31:0] pc_o,
  output logic [1:0]       valid_o,
  output bpu_predict_t     predict_o,
  input  bpu_correct_t     correct_i
);

  localparam int BTB_DEPTH  = 1 << `NPC_BTB_ADDR_WIDTH;
  localparam int BHT_DEPTH  = 1 << `NPC_BHT_ADDR_WIDTH;
  localparam int LPHT_DEPTH = 1 << `NPC_LPHT_ADDR_WIDTH;

  logic                            advance;
  logic [31:0]                     pc_q;
  logic [31:0]                     next_pc;
  logic [31:0]                     pred_npc;
  logic [31:0]                     seq_pc;
  logic [31:0]                     btb_target;
  logic [31:0]                     push_addr;
  logic [31:0]                     ras_top;
  ras_ptr_t                        ras_ptr;

  btb_entry_t                      btb_q;
  btb_entry_t                      btb_wdata;
  logic                            btb_we;
  logic                            btb_re;
  logic [`NPC_BTB_ADDR_WIDTH-1:0]  btb_waddr;
  logic [`NPC_BTB_ADDR_WIDTH-1:0]  btb_raddr;

  logic                            bht_we;
  logic [`NPC_BHT_ADDR_WIDTH-1:0]  bht_waddr;
  logic [`NPC_BHT_ADDR_WIDTH-1:0]  bht_addr_q;
  logic [`NPC_BHT_DATA_WIDTH-1:0]  bht_wdata;
  logic [`NPC_BHT_DATA_WIDTH-1:0]  bht_data;

  logic                            lpht_we;
  logic [`NPC_LPHT_ADDR_WIDTH-1:0] lpht_waddr;
  logic [`NPC_LPHT_ADDR_WIDTH-1:0] lpht_raddr;
  logic [1:0]                      lpht_wdata;
  logic [1:0]                      lpht_q;

  logic                            hit;
  logic                            pred_taken;
  logic                            ras_push;
  logic                            ras_pop;
  logic                            ras_repair;

  assign advance = !stall_i || redirect_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q       <= `NPC_RESET_PC;
      bht_addr_q <= bht_index(`NPC_RESET_PC);
    end else if (advance) begin
      pc_q       <= next_pc;
      bht_addr_q <= bht_index(next_pc);
    end
  end

  // both slots share the aligned group address
  assign pc_o[0] = {pc_q[31:3], 1'b0, pc_q[1:0]};
  assign pc_o[1] = {pc_q[31:3], 1'b1, pc_q[1:0]};

  assign seq_pc     = pc_o[0] + 32'd8;
  assign btb_target = {btb_q.target_pc, 2'b00};
  assign hit        = btb_q.valid && (btb_q.tag == btb_tag(pc_q)) &&
                      (!pc_q[2] || btb_q.fsc);

  always_comb begin
    pred_taken = 1'b0;
    pred_npc   = seq_pc;
    ras_push   = 1'b0;
    ras_pop    = 1'b0;
    if (hit) begin
      if (btb_q.uncond) begin
        case (btb_q.target_type)
          TGT_RETURN: begin
            pred_taken = 1'b1;
            pred_npc   = ras_top;
            ras_pop    = !redirect_i;
          end
          TGT_CALL: begin
            pred_taken = 1'b1;
            pred_npc   = btb_target;
            ras_push   = !redirect_i;
          end
          TGT_IMM: begin
            pred_taken = 1'b1;
            pred_npc   = btb_target;
          end
          default: begin
            pred_taken = 1'b0;
          end
        endcase
      end else if (lpht_q[1]) begin
        pred_taken = 1'b1;
        pred_npc   = btb_target;
      end
    end
  end

  assign next_pc = redirect_i ? redirect_target_i : pred_npc;

  always_comb begin
    if (stall_i) begin
      valid_o = 2'b00;
    end else if (pred_taken && !btb_q.fsc) begin
      valid_o = 2'b01;
    end else begin
      valid_o = pc_q[2] ? 2'b10 : 2'b11;
    end
  end

  assign predict_o.taken   = pred_taken;
  assign predict_o.target  = pred_npc;
  assign predict_o.history = bht_data;
  assign predict_o.lphr    = lpht_q;
  assign predict_o.ras_ptr = ras_ptr;

  // return address of the call slot
  assign push_addr  = (btb_q.fsc ? pc_o[1] : pc_o[0]) + 32'd4;
  assign ras_repair = correct_i.miss && !((ras_push || ras_pop) && !stall_i);

  // reset reloads the entry for the reset pc
  assign btb_raddr  = rst_n ? btb_index(next_pc) : btb_index(`NPC_RESET_PC);
  assign btb_re     = advance || !rst_n;
  assign lpht_raddr = lpht_index(bht_data, pc_q);

  always_comb begin
    btb_we                = correct_i.miss;
    btb_waddr             = btb_index(correct_i.pc);
    btb_wdata.valid       = 1'b1;
    btb_wdata.fsc         = correct_i.pc[2];
    btb_wdata.tag         = btb_tag(correct_i.pc);
    btb_wdata.target_pc   = correct_i.true_target[31:2];
    btb_wdata.uncond      = correct_i.true_uncond;
    btb_wdata.target_type = correct_i.true_target_type;

    // direction tables train on conditional branches only
    bht_we     = correct_i.miss && !correct_i.true_uncond;
    bht_waddr  = bht_index(correct_i.pc);
    bht_wdata  = {correct_i.history[`NPC_BHT_DATA_WIDTH-2:0], correct_i.true_taken};

    lpht_we    = bht_we;
    lpht_waddr = lpht_index(bht_wdata, correct_i.pc);
    lpht_wdata = next_lphr(correct_i.lphr, correct_i.true_taken);
  end

  sdp_bram #(
    .DATA_WIDTH ($bits(btb_entry_t)),
    .DEPTH      (BTB_DEPTH)
  ) btb_table (
    .clk     (clk),
    .we_i    (btb_we),
    .waddr_i (btb_waddr),
    .wdata_i (btb_wdata),
    .re_i    (btb_re),
    .raddr_i (btb_raddr),
    .rdata_o (btb_q)
  );

  sdp_lutram #(
    .DATA_WIDTH (`NPC_BHT_DATA_WIDTH),
    .DEPTH      (BHT_DEPTH)
  ) bht_table (
    .clk     (clk),
    .we_i    (bht_we),
    .waddr_i (bht_waddr),
    .wdata_i (bht_wdata),
    .raddr_i (bht_addr_q),
    .rdata_o (bht_data)
  );

  sdp_lutram #(
    .DATA_WIDTH (2),
    .DEPTH      (LPHT_DEPTH)
  ) lpht_table (
    .clk     (clk),
    .we_i    (lpht_we),
    .waddr_i (lpht_waddr),
    .wdata_i (lpht_wdata),
    .raddr_i (lpht_raddr),
    .rdata_o (lpht_q)
  );

  npc_ras u_ras (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .push_i        (ras_push),
    .pop_i         (ras_pop),
    .push_addr_i   (push_addr),
    .repair_i      (ras_repair),
    .repair_ptr_i  (correct_i.ras_ptr),
    .repair_call_i (correct_i.true_target_type == TGT_CALL),
    .repair_pc_i   (correct_i.pc),
    .top_o         (ras_top),
    .ptr_o         (ras_ptr)
  );

endmodule

//--- npc/npc_ras.sv
`timescale 1ns/1ns

module npc_ras import npc_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stall_i,
  input  logic        push_i,
  input  logic        pop_i,
  input  logic [31:0] push_addr_i,
  input  logic        repair_i,
  input  ras_ptr_t    repair_ptr_i,
  input  logic        repair_call_i,
  input  logic [31:0] repair_pc_i,
  output logic [31:0] top_o,
  output ras_ptr_t    ptr_o
);

  localparam int DEPTH = 1 << $bits(ras_ptr_t);

  logic [31:0] stack [DEPTH];
  // wr_ptr is the next free slot, rd_ptr the current top
  ras_ptr_t    wr_ptr;
  ras_ptr_t    rd_ptr;
  logic        spec_push;
  logic        spec_pop;

  assign spec_push = push_i && !stall_i;
  assign spec_pop  = pop_i && !stall_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (spec_push) begin
      rd_ptr <= wr_ptr;
      wr_ptr <= wr_ptr + 1'b1;
    end else if (spec_pop) begin
      wr_ptr <= wr_ptr - 1'b1;
      rd_ptr <= rd_ptr - 1'b1;
    end else if (repair_i) begin
      // rebuild from the pointer the branch was predicted with
      if (repair_call_i) begin
        wr_ptr <= repair_ptr_i + 1'b1;
        rd_ptr <= repair_ptr_i;
      end else begin
        wr_ptr <= repair_ptr_i;
        rd_ptr <= repair_ptr_i - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (spec_push) begin
      stack[wr_ptr] <= push_addr_i;
    end else if (repair_i && repair_call_i) begin
      stack[repair_ptr_i] <= repair_pc_i + 32'd4;
    end
  end

  assign top_o = stack[rd_ptr];
  assign ptr_o = wr_ptr;

endmodule

//--- src/sdp_lutram.sv
`timescale 1ns/1ns

module sdp_lutram #(
  parameter int DATA_WIDTH = 4,
  parameter int DEPTH      = 64
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [DATA_WIDTH-1:0]    wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [DATA_WIDTH-1:0]    rdata_o
);

  logic [DATA_WIDTH-1:0] mem [DEPTH] = '{default: '0};

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // async read
  assign rdata_o = mem[raddr_i];

endmodule

//--- src/sdp_bram.sv
`timescale 1ns/1ns

module sdp_bram #(
  parameter int DATA_WIDTH = 32,
  parameter int DEPTH      = 64
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [DATA_WIDTH-1:0]    wdata_i,
  input  logic                     re_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [DATA_WIDTH-1:0]    rdata_o
);

  logic [DATA_WIDTH-1:0] mem [DEPTH] = '{default: '0};
  logic [DATA_WIDTH-1:0] rdata_q = '0;

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // read-first with the output held while re_i is low
  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_q <= mem[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- common/npc_pkg.sv
`include "npc_cfg.svh"

package npc_pkg;

  typedef enum logic [1:0] {
    TGT_NPC    = 2'd0,
    TGT_CALL   = 2'd1,
    TGT_RETURN = 2'd2,
    TGT_IMM    = 2'd3
  } target_type_e;

  typedef logic [`NPC_RAS_ADDR_WIDTH-1:0] ras_ptr_t;

  typedef struct packed {
    logic                          valid;
    logic                          fsc;
    logic [`NPC_BTB_TAG_WIDTH-1:0] tag;
    logic [29:0]                   target_pc;
    logic                          uncond;
    target_type_e                  target_type;
  } btb_entry_t;

  typedef struct packed {
    logic                           taken;
    logic [31:0]                    target;
    logic [`NPC_BHT_DATA_WIDTH-1:0] history;
    logic [1:0]                     lphr;
    ras_ptr_t                       ras_ptr;
  } bpu_predict_t;

  typedef struct packed {
    logic                           miss;
    logic [31:0]                    pc;
    logic                           true_taken;
    logic                           true_uncond;
    target_type_e                   true_target_type;
    logic [31:0]                    true_target;
    logic [`NPC_BHT_DATA_WIDTH-1:0] history;
    logic [1:0]                     lphr;
    ras_ptr_t                       ras_ptr;
  } bpu_correct_t;

  // both slots of an aligned group share one index
  function automatic logic [`NPC_BTB_ADDR_WIDTH-1:0] btb_index(logic [31:0] pc);
    return pc[`NPC_BTB_ADDR_WIDTH+2:3];
  endfunction

  function automatic logic [`NPC_BTB_TAG_WIDTH-1:0] btb_tag(logic [31:0] pc);
    return pc[`NPC_BTB_TAG_WIDTH+`NPC_BTB_ADDR_WIDTH+2:`NPC_BTB_ADDR_WIDTH+3];
  endfunction

  // fold two address fields together
  function automatic logic [`NPC_BHT_ADDR_WIDTH-1:0] bht_index(logic [31:0] pc);
    return pc[`NPC_BHT_ADDR_WIDTH+2:3] ^
           pc[2*`NPC_BHT_ADDR_WIDTH+2:`NPC_BHT_ADDR_WIDTH+3];
  endfunction

  function automatic logic [`NPC_LPHT_ADDR_WIDTH-1:0] lpht_index(
    logic [`NPC_BHT_DATA_WIDTH-1:0] hist,
    logic [31:0]                    pc
  );
    return {pc[`NPC_LPHT_ADDR_WIDTH-`NPC_BHT_DATA_WIDTH+2:3], hist};
  endfunction

  // 2-bit counter step
  function automatic logic [1:0] next_lphr(logic [1:0] old, logic taken);
    case (old)
      2'b01:   return {taken, 1'b0};
      2'b10:   return {taken, 1'b1};
      2'b11:   return {1'b1, taken};
      default: return {1'b0, taken};
    endcase
  endfunction

endpackage

//--- common/npc_cfg.svh
`ifndef NPC_CFG_SVH
`define NPC_CFG_SVH

// btb geometry
`define NPC_BTB_ADDR_WIDTH 6
`define NPC_BTB_TAG_WIDTH 12

// per-address local history
`define NPC_BHT_ADDR_WIDTH 6
`define NPC_BHT_DATA_WIDTH 4

// history bits plus two pc bits
`define NPC_LPHT_ADDR_WIDTH (`NPC_BHT_DATA_WIDTH + 2)

// 8-entry return stack
`define NPC_RAS_ADDR_WIDTH 3

// first fetch address out of reset
`define NPC_RESET_PC 32'h1c00_0000

`endif
